// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module uart_bridge_tb
	./obj_dir/Vuart_bridge_tb | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

// ==== project.f ====
source/uart_bridge_pkg.sv
source/axil_cmd_if.sv
source/axil_master.sv
source/pkt_deserializer.sv
source/word_serializer.sv
source/bridge_ctrl.sv
source/uart_axil_bridge.sv
tb/axil_slave_model.sv
tb/uart_bridge_tb.sv

// ==== source/axil_cmd_if.sv ====
`default_nettype none
`timescale 1ns/1ns

interface axil_cmd_if
  import uart_bridge_pkg::*;
#(
  parameter int addr_width = 32
) ();

  // Command channel
  logic                  cmd_v;
  logic                  cmd_w;
  logic [addr_width-1:0] cmd_addr;
  logic [word_width-1:0] cmd_data;
  logic                  cmd_ready;

  // Response channel, writes return zero data
  logic                  resp_v;
  logic [word_width-1:0] resp_data;
  logic                  resp_ready;

  modport ctrl (
    output cmd_v, cmd_w, cmd_addr, cmd_data, resp_ready,
    input  cmd_ready, resp_v, resp_data
  );

  modport master (
    input  cmd_v, cmd_w, cmd_addr, cmd_data, resp_ready,
    output cmd_ready, resp_v, resp_data
  );

endinterface

`default_nettype wire

// ==== source/axil_master.sv ====
`default_nettype none
`timescale 1ns/1ns

module axil_master
  import uart_bridge_pkg::*;
#(
  parameter int addr_width = 32
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  axil_cmd_if.master                cmd,

  output logic [addr_width-1:0]     awaddr_o,
  output logic [2:0]                awprot_o,
  output logic                      awvalid_o,
  input  logic                      awready_i,

  output logic [word_width-1:0]     wdata_o,
  output logic [word_width/8-1:0]   wstrb_o,
  output logic                      wvalid_o,
  input  logic                      wready_i,

  input  logic [1:0]                bresp_i,
  input  logic                      bvalid_i,
  output logic                      bready_o,

  output logic [addr_width-1:0]     araddr_o,
  output logic [2:0]                arprot_o,
  output logic                      arvalid_o,
  input  logic                      arready_i,

  input  logic [word_width-1:0]     rdata_i,
  input  logic [1:0]                rresp_i,
  input  logic                      rvalid_i,
  output logic                      rready_o
);

  logic                  wr_active_r;
  logic                  rd_active_r;
  logic                  awvalid_r;
  logic                  wvalid_r;
  logic                  arvalid_r;
  logic                  resp_v_r;
  logic [addr_width-1:0] addr_r;
  logic [word_width-1:0] data_r;
  logic [word_width-1:0] resp_data_r;
  logic                  cmd_fire;
  logic                  b_fire;
  logic                  r_fire;

  // One transaction in flight, busy until the response is taken
  assign cmd.cmd_ready = ~wr_active_r & ~rd_active_r;
  assign cmd_fire      = cmd.cmd_v & cmd.cmd_ready;

  assign bready_o = wr_active_r & ~awvalid_r & ~wvalid_r & ~resp_v_r;
  assign rready_o = rd_active_r & ~arvalid_r & ~resp_v_r;
  assign b_fire   = bvalid_i & bready_o;
  assign r_fire   = rvalid_i & rready_o;

  assign awaddr_o  = addr_r;
  assign araddr_o  = addr_r;
  assign wdata_o   = data_r;
  assign awvalid_o = awvalid_r;
  assign wvalid_o  = wvalid_r;
  assign arvalid_o = arvalid_r;
  assign wstrb_o   = '1;
  assign awprot_o  = 3'b000;
  assign arprot_o  = 3'b000;

  assign cmd.resp_v    = resp_v_r;
  assign cmd.resp_data = resp_data_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_active_r <= 1'b0;
      rd_active_r <= 1'b0;
      awvalid_r   <= 1'b0;
      wvalid_r    <= 1'b0;
      arvalid_r   <= 1'b0;
      resp_v_r    <= 1'b0;
    end
    else
    begin
      if (cmd_fire)
      begin
        wr_active_r <= cmd.cmd_w;
        rd_active_r <= ~cmd.cmd_w;
        awvalid_r   <= cmd.cmd_w;
        wvalid_r    <= cmd.cmd_w;
        arvalid_r   <= ~cmd.cmd_w;
      end
      else
      begin
        // aw and w complete independently
        if (awready_i)
          awvalid_r <= 1'b0;
        if (wready_i)
          wvalid_r <= 1'b0;
        if (arready_i)
          arvalid_r <= 1'b0;
        if (resp_v_r & cmd.resp_ready)
        begin
          wr_active_r <= 1'b0;
          rd_active_r <= 1'b0;
        end
      end
      if (b_fire | r_fire)
        resp_v_r <= 1'b1;
      else if (cmd.resp_ready)
        resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      addr_r <= cmd.cmd_addr;
      data_r <= cmd.cmd_data;
    end
    if (b_fire)
      resp_data_r <= '0;
    else if (r_fire)
      resp_data_r <= rdata_i;
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o));
  assert property (@(posedge clk_i) disable iff (reset_i)
    wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o));
  assert property (@(posedge clk_i) disable iff (reset_i)
    arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o));
  assert property (@(posedge clk_i) disable iff (reset_i)
    !((awvalid_o || wvalid_o || bready_o) && (arvalid_o || rready_o)));

endmodule

`default_nettype wire

// ==== source/bridge_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ns

module bridge_ctrl
  import uart_bridge_pkg::*;
#(
  parameter logic [31:0] uart_base_addr = 32'h0
) (
  input  logic    clk_i,
  input  logic    reset_i,
  axil_cmd_if.ctrl m_cmd,
  axil_cmd_if.ctrl gp0_cmd
);

  localparam int m_aw   = $bits(m_cmd.cmd_addr);
  localparam int gp0_aw = $bits(gp0_cmd.cmd_addr);

  localparam logic [31:0] rx_addr   = uart_base_addr + rx_offset;
  localparam logic [31:0] tx_addr   = uart_base_addr + tx_offset;
  localparam logic [31:0] stat_addr = uart_base_addr + stat_offset;

  bridge_state_e         state_r;
  bridge_state_e         state_n;
  uart_pkt_s             pkt;
  logic                  pkt_v;
  logic                  pkt_yumi;
  logic                  rx_v;
  logic                  rx_ready;
  logic                  tx_word_v;
  logic                  tx_word_ready;
  logic [7:0]            tx_byte;
  logic                  tx_byte_v;
  logic                  tx_byte_yumi;
  logic [word_width-1:0] gp0_addr;

  pkt_deserializer u_deser (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .byte_i     (m_cmd.resp_data[7:0]),
    .byte_v_i   (rx_v),
    .ready_o    (rx_ready),
    .pkt_o      (pkt),
    .pkt_v_o    (pkt_v),
    .pkt_yumi_i (pkt_yumi)
  );

  word_serializer u_ser (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .word_i       (gp0_cmd.resp_data),
    .word_v_i     (tx_word_v),
    .word_ready_o (tx_word_ready),
    .byte_o       (tx_byte),
    .byte_v_o     (tx_byte_v),
    .byte_yumi_i  (tx_byte_yumi)
  );

  // Word address to byte address
  assign gp0_addr = word_width'({pkt.addr7to2, 2'b00});

  always_comb
  begin
    state_n = state_r;

    m_cmd.cmd_v      = 1'b0;
    m_cmd.cmd_w      = 1'b0;
    m_cmd.cmd_addr   = stat_addr[m_aw-1:0];
    m_cmd.cmd_data   = {{(word_width-8){1'b0}}, tx_byte};
    m_cmd.resp_ready = 1'b0;

    gp0_cmd.cmd_v      = 1'b0;
    gp0_cmd.cmd_w      = pkt.wr_not_rd;
    gp0_cmd.cmd_addr   = gp0_addr[gp0_aw-1:0];
    gp0_cmd.cmd_data   = pkt.data;
    gp0_cmd.resp_ready = 1'b0;

    rx_v         = 1'b0;
    pkt_yumi     = 1'b0;
    tx_word_v    = 1'b0;
    tx_byte_yumi = 1'b0;

    case (state_r)
      e_reset:
        state_n = e_ready;
      // Run a pending packet, otherwise poll STAT
      e_ready:
      begin
        m_cmd.cmd_v = ~pkt_v;
        if (pkt_v)
          state_n = e_req_send;
        else if (m_cmd.cmd_ready)
          state_n = e_poll_check;
      end
      e_poll_check:
      begin
        m_cmd.resp_ready = 1'b1;
        if (m_cmd.resp_v)
          state_n = m_cmd.resp_data[0] ? e_poll_send : e_ready;
      end
      e_poll_send:
      begin
        m_cmd.cmd_v    = 1'b1;
        m_cmd.cmd_addr = rx_addr[m_aw-1:0];
        if (m_cmd.cmd_ready)
          state_n = e_poll_recv;
      end
      e_poll_recv:
      begin
        rx_v             = m_cmd.resp_v;
        m_cmd.resp_ready = rx_ready;
        if (m_cmd.resp_v & rx_ready)
          state_n = e_ready;
      end
      e_req_send:
      begin
        gp0_cmd.cmd_v = 1'b1;
        if (gp0_cmd.cmd_ready)
          state_n = e_req_wait;
      end
      // Read data goes to the serializer in the same cycle the packet is dropped
      e_req_wait:
      begin
        tx_word_v          = gp0_cmd.resp_v & ~pkt.wr_not_rd;
        gp0_cmd.resp_ready = pkt.wr_not_rd | tx_word_ready;
        pkt_yumi           = gp0_cmd.resp_v & gp0_cmd.resp_ready;
        if (pkt_yumi)
          state_n = pkt.wr_not_rd ? e_ready : e_tx_send;
      end
      e_tx_send:
      begin
        m_cmd.cmd_v    = tx_byte_v;
        m_cmd.cmd_w    = 1'b1;
        m_cmd.cmd_addr = tx_addr[m_aw-1:0];
        tx_byte_yumi   = tx_byte_v & m_cmd.cmd_ready;
        if (tx_byte_yumi)
          state_n = e_tx_drain;
      end
      e_tx_drain:
      begin
        m_cmd.resp_ready = 1'b1;
        if (m_cmd.resp_v)
          state_n = tx_byte_v ? e_tx_send : e_ready;
      end
      default:
        state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_reset;
    else
      state_r <= state_n;
  end

  // Held packet drops only after a cycle with the gp0 response valid
  assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(pkt_v) |-> $past(gp0_cmd.resp_v));
  assert property (@(posedge clk_i) disable iff (reset_i)
    gp0_cmd.resp_v |-> state_r == e_req_wait);

endmodule

`default_nettype wire

// ==== source/pkt_deserializer.sv ====
`default_nettype none
`timescale 1ns/1ns

module pkt_deserializer
  import uart_bridge_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic [7:0] byte_i,
  input  logic       byte_v_i,
  output logic       ready_o,
  output uart_pkt_s  pkt_o,
  output logic       pkt_v_o,
  input  logic       pkt_yumi_i
);

  localparam int count_width = $clog2(pkt_bytes);

  logic [pkt_bytes*8-1:0]  shift_r;
  logic [count_width-1:0]  count_r;
  logic                    pkt_v_r;
  logic                    byte_fire;

  // No new bytes while a full packet is held
  assign ready_o   = ~pkt_v_r;
  assign byte_fire = byte_v_i & ready_o;
  assign pkt_o     = uart_pkt_s'(shift_r);
  assign pkt_v_o   = pkt_v_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      count_r <= '0;
      pkt_v_r <= 1'b0;
    end
    else if (byte_fire)
    begin
      if (count_r == count_width'(pkt_bytes - 1))
      begin
        count_r <= '0;
        pkt_v_r <= 1'b1;
      end
      else
        count_r <= count_r + 1'b1;
    end
    else if (pkt_yumi_i)
      pkt_v_r <= 1'b0;
  end

  // Shift in from the top so the first byte ends up lowest
  always_ff @(posedge clk_i)
  begin
    if (byte_fire)
      shift_r <= {byte_i, shift_r[pkt_bytes*8-1:8]};
  end

  assert property (@(posedge clk_i) disable iff (reset_i) pkt_yumi_i |-> pkt_v_o);

endmodule

`default_nettype wire

// ==== source/uart_axil_bridge.sv ====
`default_nettype none
`timescale 1ns/1ns

module uart_axil_bridge
  import uart_bridge_pkg::*;
#(
  parameter int          m_addr_width   = 32,
  parameter int          gp0_addr_width = 32,
  parameter logic [31:0] uart_base_addr = 32'h0
) (
  input  logic                        clk_i,
  input  logic                        reset_i,

  output logic [m_addr_width-1:0]     m_axil_awaddr_o,
  output logic [2:0]                  m_axil_awprot_o,
  output logic                        m_axil_awvalid_o,
  input  logic                        m_axil_awready_i,
  output logic [word_width-1:0]       m_axil_wdata_o,
  output logic [word_width/8-1:0]     m_axil_wstrb_o,
  output logic                        m_axil_wvalid_o,
  input  logic                        m_axil_wready_i,
  input  logic [1:0]                  m_axil_bresp_i,
  input  logic                        m_axil_bvalid_i,
  output logic                        m_axil_bready_o,
  output logic [m_addr_width-1:0]     m_axil_araddr_o,
  output logic [2:0]                  m_axil_arprot_o,
  output logic                        m_axil_arvalid_o,
  input  logic                        m_axil_arready_i,
  input  logic [word_width-1:0]       m_axil_rdata_i,
  input  logic [1:0]                  m_axil_rresp_i,
  input  logic                        m_axil_rvalid_i,
  output logic                        m_axil_rready_o,

  output logic [gp0_addr_width-1:0]   gp0_axil_awaddr_o,
  output logic [2:0]                  gp0_axil_awprot_o,
  output logic                        gp0_axil_awvalid_o,
  input  logic                        gp0_axil_awready_i,
  output logic [word_width-1:0]       gp0_axil_wdata_o,
  output logic [word_width/8-1:0]     gp0_axil_wstrb_o,
  output logic                        gp0_axil_wvalid_o,
  input  logic                        gp0_axil_wready_i,
  input  logic [1:0]                  gp0_axil_bresp_i,
  input  logic                        gp0_axil_bvalid_i,
  output logic                        gp0_axil_bready_o,
  output logic [gp0_addr_width-1:0]   gp0_axil_araddr_o,
  output logic [2:0]                  gp0_axil_arprot_o,
  output logic                        gp0_axil_arvalid_o,
  input  logic                        gp0_axil_arready_i,
  input  logic [word_width-1:0]       gp0_axil_rdata_i,
  input  logic [1:0]                  gp0_axil_rresp_i,
  input  logic                        gp0_axil_rvalid_i,
  output logic                        gp0_axil_rready_o
);

  axil_cmd_if #(.addr_width(m_addr_width))   m_cmd ();
  axil_cmd_if #(.addr_width(gp0_addr_width)) gp0_cmd ();

  // UART register port
  axil_master #(.addr_width(m_addr_width)) u_m_master (
    .clk_i (clk_i), .reset_i (reset_i), .cmd (m_cmd.master),
    .awaddr_o (m_axil_awaddr_o), .awprot_o (m_axil_awprot_o),
    .awvalid_o (m_axil_awvalid_o), .awready_i (m_axil_awready_i),
    .wdata_o (m_axil_wdata_o), .wstrb_o (m_axil_wstrb_o),
    .wvalid_o (m_axil_wvalid_o), .wready_i (m_axil_wready_i),
    .bresp_i (m_axil_bresp_i), .bvalid_i (m_axil_bvalid_i), .bready_o (m_axil_bready_o),
    .araddr_o (m_axil_araddr_o), .arprot_o (m_axil_arprot_o),
    .arvalid_o (m_axil_arvalid_o), .arready_i (m_axil_arready_i),
    .rdata_i (m_axil_rdata_i), .rresp_i (m_axil_rresp_i),
    .rvalid_i (m_axil_rvalid_i), .rready_o (m_axil_rready_o)
  );

  // Target port for host commands
  axil_master #(.addr_width(gp0_addr_width)) u_gp0_master (
    .clk_i (clk_i), .reset_i (reset_i), .cmd (gp0_cmd.master),
    .awaddr_o (gp0_axil_awaddr_o), .awprot_o (gp0_axil_awprot_o),
    .awvalid_o (gp0_axil_awvalid_o), .awready_i (gp0_axil_awready_i),
    .wdata_o (gp0_axil_wdata_o), .wstrb_o (gp0_axil_wstrb_o),
    .wvalid_o (gp0_axil_wvalid_o), .wready_i (gp0_axil_wready_i),
    .bresp_i (gp0_axil_bresp_i), .bvalid_i (gp0_axil_bvalid_i),
    .bready_o (gp0_axil_bready_o),
    .araddr_o (gp0_axil_araddr_o), .arprot_o (gp0_axil_arprot_o),
    .arvalid_o (gp0_axil_arvalid_o), .arready_i (gp0_axil_arready_i),
    .rdata_i (gp0_axil_rdata_i), .rresp_i (gp0_axil_rresp_i),
    .rvalid_i (gp0_axil_rvalid_i), .rready_o (gp0_axil_rready_o)
  );

  bridge_ctrl #(.uart_base_addr(uart_base_addr)) u_ctrl (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .m_cmd   (m_cmd.ctrl),
    .gp0_cmd (gp0_cmd.ctrl)
  );

endmodule

`default_nettype wire

// ==== source/uart_bridge_pkg.sv ====
`default_nettype none

package uart_bridge_pkg;

  localparam int pkt_bytes  = 5;
  localparam int word_width = 32;

  // UART register map, relative to the base address
  localparam logic [31:0] rx_offset   = 32'h0;
  localparam logic [31:0] tx_offset   = 32'h4;
  localparam logic [31:0] stat_offset = 32'h8;

  // First received byte lands in bits 7:0
  typedef struct packed
  {
    logic [word_width-1:0] data;
    logic [5:0]            addr7to2;
    logic                  wr_not_rd;
    logic                  port;
  } uart_pkt_s;

  typedef enum logic [3:0]
  {
    e_reset,
    e_ready,
    e_poll_check,
    e_poll_send,
    e_poll_recv,
    e_req_send,
    e_req_wait,
    e_tx_send,
    e_tx_drain
  } bridge_state_e;

endpackage

`default_nettype wire

// ==== source/word_serializer.sv ====
`default_nettype none
`timescale 1ns/1ns

module word_serializer
  import uart_bridge_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [word_width-1:0] word_i,
  input  logic                  word_v_i,
  output logic                  word_ready_o,
  output logic [7:0]            byte_o,
  output logic                  byte_v_o,
  input  logic                  byte_yumi_i
);

  localparam int word_bytes  = word_width / 8;
  localparam int count_width = $clog2(word_bytes + 1);

  logic [word_width-1:0]  shift_r;
  logic [count_width-1:0] remain_r;
  logic                   load;

  assign word_ready_o = (remain_r == '0);
  assign byte_v_o     = (remain_r != '0);
  assign byte_o       = shift_r[7:0];
  assign load         = word_v_i & word_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      remain_r <= '0;
    else if (load)
      remain_r <= count_width'(word_bytes);
    else if (byte_yumi_i & byte_v_o)
      remain_r <= remain_r - 1'b1;
  end

  // Least significant byte goes out first
  always_ff @(posedge clk_i)
  begin
    if (load)
      shift_r <= word_i;
    else if (byte_yumi_i & byte_v_o)
      shift_r <= {8'h00, shift_r[word_width-1:8]};
  end

  // Serializer must not be reloaded or popped past empty by the controller
  assert property (@(posedge clk_i) disable iff (reset_i) byte_yumi_i |-> byte_v_o);

endmodule

`default_nettype wire

// ==== tb/axil_slave_model.sv ====
`default_nettype none
`timescale 1ns/1ns

module axil_slave_model
#(
  parameter int          addr_width = 32,
  parameter bit          uart_mode  = 1'b0,
  parameter logic [31:0] base_addr  = 32'h0
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [addr_width-1:0] awaddr_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,
  input  logic [31:0]           wdata_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,
  output logic [1:0]            bresp_o,
  output logic                  bvalid_o,
  input  logic                  bready_i,
  input  logic [addr_width-1:0] araddr_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  output logic [31:0]           rdata_o,
  output logic [1:0]            rresp_o,
  output logic                  rvalid_o,
  input  logic                  rready_i,
  // Ready enables, one random bit each per cycle
  input  logic                  aw_ok_i,
  input  logic                  w_ok_i,
  input  logic                  ar_ok_i,
  input  logic                  rx_avail_i,
  input  logic [7:0]            rx_byte_i,
  output logic                  rx_pop_o,
  output logic                  wr_commit_o,
  output logic [31:0]           wr_addr_o,
  output logic [31:0]           wr_data_o
);

  logic [31:0] mem_r [64];
  logic        aw_got_r;
  logic        w_got_r;
  logic        bvalid_r;
  logic        rvalid_r;
  logic [31:0] awaddr_r;
  logic [31:0] wdata_r;
  logic [31:0] rdata_r;
  logic [31:0] rd_offset;
  logic [31:0] wr_offset;
  logic [31:0] rd_word;

  assign awready_o   = aw_ok_i & ~aw_got_r;
  assign wready_o    = w_ok_i & ~w_got_r;
  assign arready_o   = ar_ok_i & ~rvalid_r;
  assign bvalid_o    = bvalid_r;
  assign rvalid_o    = rvalid_r;
  assign rdata_o     = rdata_r;
  assign bresp_o     = 2'b00;
  assign rresp_o     = 2'b00;
  assign wr_commit_o = aw_got_r & w_got_r;
  assign wr_addr_o   = awaddr_r;
  assign wr_data_o   = wdata_r;
  assign wr_offset   = awaddr_r - base_addr;

  // UART map: RX at 0x0, STAT at 0x8 with bit 0 as RX available
  always_comb
  begin
    rd_offset = 32'(araddr_i) - base_addr;
    if (!uart_mode)
      rd_word = mem_r[rd_offset[7:2]];
    else if (rd_offset == 32'h8)
      rd_word = {31'b0, rx_avail_i};
    else if (rd_offset == 32'h0)
      rd_word = {24'b0, rx_byte_i};
    else
      rd_word = 32'h0;
  end

  assign rx_pop_o = uart_mode & arvalid_i & arready_o & (rd_offset == 32'h0);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      aw_got_r <= 1'b0;
      w_got_r  <= 1'b0;
      bvalid_r <= 1'b0;
      rvalid_r <= 1'b0;
    end
    else
    begin
      if (awvalid_i & awready_o)
        aw_got_r <= 1'b1;
      if (wvalid_i & wready_o)
        w_got_r <= 1'b1;
      if (wr_commit_o)
      begin
        aw_got_r <= 1'b0;
        w_got_r  <= 1'b0;
        bvalid_r <= 1'b1;
      end
      else if (bvalid_r & bready_i)
        bvalid_r <= 1'b0;
      if (arvalid_i & arready_o)
        rvalid_r <= 1'b1;
      else if (rvalid_r & rready_i)
        rvalid_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (awvalid_i & awready_o)
      awaddr_r <= 32'(awaddr_i);
    if (wvalid_i & wready_o)
      wdata_r <= wdata_i;
    if (arvalid_i & arready_o)
      rdata_r <= rd_word;
  end

  // Word memory starts out all zero
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < 64; i++)
        mem_r[i] <= 32'h0;
    end
    else if (wr_commit_o && !uart_mode)
      mem_r[wr_offset[7:2]] <= wdata_r;
  end

endmodule

`default_nettype wire

// ==== tb/uart_bridge_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

module uart_bridge_tb;

  localparam int          m_aw             = 16;
  localparam int          gp0_aw           = 12;
  localparam logic [31:0] uart_base        = 32'h0000_1000;
  localparam logic [31:0] stat_addr        = uart_base + 32'h8;
  localparam logic [31:0] tx_addr          = uart_base + 32'h4;
  localparam int          clk_period       = 4;
  localparam int          reset_cycles     = 16;
  localparam int          idle_cycles      = 200;
  localparam int          drain_cycles     = 400;
  localparam int          num_cmds         = 15;
  localparam int          cmd_bound_cycles = 1500;
  localparam int          timeout_ns       =
    (reset_cycles + idle_cycles + drain_cycles + num_cmds * cmd_bound_cycles) * clk_period;

  typedef struct packed
  {
    logic        wr;
    logic        port;
    logic [5:0]  addr;
    logic [31:0] data;
    logic [31:0] exp_data;
  } cmd_entry_s;

  logic clk_i;
  logic reset_i;

  logic [m_aw-1:0]   m_axil_awaddr_o;
  logic [2:0]        m_axil_awprot_o;
  logic              m_axil_awvalid_o;
  logic              m_axil_awready_i;
  logic [31:0]       m_axil_wdata_o;
  logic [3:0]        m_axil_wstrb_o;
  logic              m_axil_wvalid_o;
  logic              m_axil_wready_i;
  logic [1:0]        m_axil_bresp_i;
  logic              m_axil_bvalid_i;
  logic              m_axil_bready_o;
  logic [m_aw-1:0]   m_axil_araddr_o;
  logic [2:0]        m_axil_arprot_o;
  logic              m_axil_arvalid_o;
  logic              m_axil_arready_i;
  logic [31:0]       m_axil_rdata_i;
  logic [1:0]        m_axil_rresp_i;
  logic              m_axil_rvalid_i;
  logic              m_axil_rready_o;

  logic [gp0_aw-1:0] gp0_axil_awaddr_o;
  logic [2:0]        gp0_axil_awprot_o;
  logic              gp0_axil_awvalid_o;
  logic              gp0_axil_awready_i;
  logic [31:0]       gp0_axil_wdata_o;
  logic [3:0]        gp0_axil_wstrb_o;
  logic              gp0_axil_wvalid_o;
  logic              gp0_axil_wready_i;
  logic [1:0]        gp0_axil_bresp_i;
  logic              gp0_axil_bvalid_i;
  logic              gp0_axil_bready_o;
  logic [gp0_aw-1:0] gp0_axil_araddr_o;
  logic [2:0]        gp0_axil_arprot_o;
  logic              gp0_axil_arvalid_o;
  logic              gp0_axil_arready_i;
  logic [31:0]       gp0_axil_rdata_i;
  logic [1:0]        gp0_axil_rresp_i;
  logic              gp0_axil_rvalid_i;
  logic              gp0_axil_rready_o;

  logic        m_aw_ok;
  logic        m_w_ok;
  logic        m_ar_ok;
  logic        gp0_aw_ok;
  logic        gp0_w_ok;
  logic        gp0_ar_ok;
  logic        rx_avail;
  logic [7:0]  rx_head;
  logic        rx_pop;
  logic        uart_wr;
  logic [31:0] uart_wr_addr;
  logic [31:0] uart_wr_data;
  logic        mem_wr;
  logic [31:0] mem_wr_addr;
  logic [31:0] mem_wr_data;

  logic [7:0]  rx_q [$];
  logic [7:0]  tx_q [$];
  logic [31:0] shadow_mem [64];
  cmd_entry_s  cmd_table [num_cmds];
  logic [31:0] lfsr_state;
  logic [31:0] last_wr_addr;
  logic [31:0] last_wr_data;
  logic        idle_phase;
  int          mem_writes;

  uart_axil_bridge #(
    .m_addr_width   (m_aw),
    .gp0_addr_width (gp0_aw),
    .uart_base_addr (uart_base)
  ) u_dut (.*);

  axil_slave_model #(.addr_width(m_aw), .uart_mode(1'b1), .base_addr(uart_base)) u_uart (
    .clk_i (clk_i), .reset_i (reset_i),
    .awaddr_i (m_axil_awaddr_o), .awvalid_i (m_axil_awvalid_o),
    .awready_o (m_axil_awready_i),
    .wdata_i (m_axil_wdata_o), .wvalid_i (m_axil_wvalid_o), .wready_o (m_axil_wready_i),
    .bresp_o (m_axil_bresp_i), .bvalid_o (m_axil_bvalid_i), .bready_i (m_axil_bready_o),
    .araddr_i (m_axil_araddr_o), .arvalid_i (m_axil_arvalid_o),
    .arready_o (m_axil_arready_i),
    .rdata_o (m_axil_rdata_i), .rresp_o (m_axil_rresp_i),
    .rvalid_o (m_axil_rvalid_i), .rready_i (m_axil_rready_o),
    .aw_ok_i (m_aw_ok), .w_ok_i (m_w_ok), .ar_ok_i (m_ar_ok),
    .rx_avail_i (rx_avail), .rx_byte_i (rx_head), .rx_pop_o (rx_pop),
    .wr_commit_o (uart_wr), .wr_addr_o (uart_wr_addr), .wr_data_o (uart_wr_data)
  );

  axil_slave_model #(.addr_width(gp0_aw), .uart_mode(1'b0), .base_addr(32'h0)) u_mem (
    .clk_i (clk_i), .reset_i (reset_i),
    .awaddr_i (gp0_axil_awaddr_o), .awvalid_i (gp0_axil_awvalid_o),
    .awready_o (gp0_axil_awready_i),
    .wdata_i (gp0_axil_wdata_o), .wvalid_i (gp0_axil_wvalid_o),
    .wready_o (gp0_axil_wready_i),
    .bresp_o (gp0_axil_bresp_i), .bvalid_o (gp0_axil_bvalid_i),
    .bready_i (gp0_axil_bready_o),
    .araddr_i (gp0_axil_araddr_o), .arvalid_i (gp0_axil_arvalid_o),
    .arready_o (gp0_axil_arready_i),
    .rdata_o (gp0_axil_rdata_i), .rresp_o (gp0_axil_rresp_i),
    .rvalid_o (gp0_axil_rvalid_i), .rready_i (gp0_axil_rready_o),
    .aw_ok_i (gp0_aw_ok), .w_ok_i (gp0_w_ok), .ar_ok_i (gp0_ar_ok),
    .rx_avail_i (1'b0), .rx_byte_i (8'h00), .rx_pop_o (),
    .wr_commit_o (mem_wr), .wr_addr_o (mem_wr_addr), .wr_data_o (mem_wr_data)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  function logic take_bit();
    lfsr_state = lfsr_next(lfsr_state);
    return lfsr_state[0];
  endfunction

  task automatic abort_run(input string reason);
    $display("%s at %0t ns", reason, $time);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
      $display("TEST FAIL");
      $fatal(1, "simulation stopped");
    end
  endtask

  task automatic step_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // Feed one packet, LSB byte first, then wait for its effect
  task automatic run_command(input cmd_entry_s cmd);
    logic [39:0] pkt_bits;
    logic [31:0] word;
    int          writes_before;
    int          b;
    pkt_bits      = {cmd.data, cmd.addr, cmd.wr, cmd.port};
    writes_before = mem_writes;
    compare_value("tx bytes before command", 32'(tx_q.size()), 32'h0);
    for (b = 0; b < 5; b++)
      rx_q.push_back(pkt_bits[b*8 +: 8]);
    if (cmd.wr)
    begin
      while (mem_writes == writes_before)
        step_cycle();
      shadow_mem[cmd.addr] = cmd.data;
      compare_value("gp0_axil_awaddr_o", last_wr_addr, {24'h0, cmd.addr, 2'b00});
      compare_value("gp0_axil_wdata_o", last_wr_data, cmd.data);
      compare_value("tx bytes after a write", 32'(tx_q.size()), 32'h0);
    end
    else
    begin
      while (tx_q.size() < 4)
        step_cycle();
      word = {tx_q[3], tx_q[2], tx_q[1], tx_q[0]};
      compare_value("read word from tx bytes", word, cmd.exp_data);
      compare_value("read word against shadow memory", word, shadow_mem[cmd.addr]);
      compare_value("gp0 writes during a read", 32'(mem_writes), 32'(writes_before));
      tx_q.delete();
    end
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  // Random ready enables and the RX queue head, just after each edge
  initial
  begin
    lfsr_state = 32'hb9864c7c;
    forever
    begin
      step_cycle();
      m_aw_ok   = take_bit();
      m_w_ok    = take_bit();
      m_ar_ok   = take_bit();
      gp0_aw_ok = take_bit();
      gp0_w_ok  = take_bit();
      gp0_ar_ok = take_bit();
      rx_avail  = (rx_q.size() != 0);
      if (rx_avail)
        rx_head = rx_q[0];
      else
        rx_head = 8'h00;
    end
  end

  always @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      compare_value("m_axil_wstrb_o", 32'(m_axil_wstrb_o), 32'hf);
      compare_value("gp0_axil_wstrb_o", 32'(gp0_axil_wstrb_o), 32'hf);
      compare_value("awprot_o and arprot_o",
        32'({m_axil_awprot_o, m_axil_arprot_o, gp0_axil_awprot_o, gp0_axil_arprot_o}), 32'h0);
    end
    if (idle_phase)
    begin
      compare_value("gp0 valids while idle",
        32'({gp0_axil_awvalid_o, gp0_axil_wvalid_o, gp0_axil_arvalid_o}), 32'h0);
      compare_value("m write valids while idle",
        32'({m_axil_awvalid_o, m_axil_wvalid_o}), 32'h0);
      if (m_axil_arvalid_o)
        compare_value("m_axil_araddr_o", 32'(m_axil_araddr_o), stat_addr);
    end
    if (rx_pop)
    begin
      if (rx_q.size() == 0)
        abort_run("RX register read while the host queue is empty");
      else
        void'(rx_q.pop_front());
    end
    if (uart_wr)
    begin
      compare_value("m_axil_awaddr_o", uart_wr_addr, tx_addr);
      tx_q.push_back(uart_wr_data[7:0]);
    end
    if (mem_wr)
    begin
      mem_writes++;
      last_wr_addr = mem_wr_addr;
      last_wr_data = mem_wr_data;
    end
  end

  initial
  begin
    #(timeout_ns);
    abort_run("watchdog expired before all commands completed");
  end

  initial
  begin : main_proc
    int i;
    int expected_writes;
    reset_i         = 1'b1;
    m_aw_ok         = 1'b0;
    m_w_ok          = 1'b0;
    m_ar_ok         = 1'b0;
    gp0_aw_ok       = 1'b0;
    gp0_w_ok        = 1'b0;
    gp0_ar_ok       = 1'b0;
    rx_avail        = 1'b0;
    rx_head         = 8'h00;
    idle_phase      = 1'b0;
    mem_writes      = 0;
    expected_writes = 0;
    for (i = 0; i < 64; i++)
      shadow_mem[i] = 32'h0;

    // wr, port, addr7to2, data, expected read word
    cmd_table = '{
      '{1'b0, 1'b0, 6'd5,  32'h0000_0000, 32'h0000_0000},
      '{1'b0, 1'b1, 6'd5,  32'hffff_ffff, 32'h0000_0000},
      '{1'b1, 1'b0, 6'd3,  32'hdead_beef, 32'h0000_0000},
      '{1'b0, 1'b0, 6'd3,  32'h0000_0000, 32'hdead_beef},
      '{1'b1, 1'b0, 6'd0,  32'h0123_4567, 32'h0000_0000},
      '{1'b1, 1'b1, 6'd63, 32'h89ab_cdef, 32'h0000_0000},
      '{1'b0, 1'b0, 6'd0,  32'h0000_0000, 32'h0123_4567},
      '{1'b0, 1'b1, 6'd63, 32'h0000_0000, 32'h89ab_cdef},
      '{1'b1, 1'b0, 6'd3,  32'ha5a5_5a5a, 32'h0000_0000},
      '{1'b0, 1'b0, 6'd3,  32'h0000_0000, 32'ha5a5_5a5a},
      '{1'b1, 1'b0, 6'd42, 32'h0000_00ff, 32'h0000_0000},
      '{1'b0, 1'b1, 6'd42, 32'h0000_0000, 32'h0000_00ff},
      '{1'b0, 1'b0, 6'd62, 32'h1234_5678, 32'h0000_0000},
      '{1'b1, 1'b1, 6'd17, 32'h8000_0001, 32'h0000_0000},
      '{1'b0, 1'b0, 6'd17, 32'h0000_0000, 32'h8000_0001}
    };

    repeat (reset_cycles) @(posedge clk_i);
    #1;
    compare_value("valid, bready and rready in reset",
      32'({m_axil_awvalid_o, m_axil_wvalid_o, m_axil_arvalid_o, m_axil_bready_o,
           m_axil_rready_o, gp0_axil_awvalid_o, gp0_axil_wvalid_o, gp0_axil_arvalid_o,
           gp0_axil_bready_o, gp0_axil_rready_o}), 32'h0);
    reset_i    = 1'b0;
    idle_phase = 1'b1;
    repeat (idle_cycles) step_cycle();
    idle_phase = 1'b0;

    for (i = 0; i < num_cmds; i++)
    begin
      if (cmd_table[i].wr)
        expected_writes++;
      run_command(cmd_table[i]);
    end

    // Late or duplicated bytes would show up here
    repeat (drain_cycles) step_cycle();
    compare_value("tx bytes left over", 32'(tx_q.size()), 32'h0);
    compare_value("rx bytes left over", 32'(rx_q.size()), 32'h0);
    compare_value("gp0 write count", 32'(mem_writes), 32'(expected_writes));

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire
